// File: Makefile
# Verilator build and run of the MIPS pipeline testbench.

VERILATOR ?= verilator
TOP       ?= mips_core_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT := ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// File: design/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_defines.svh"

module decode_stage (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire mips_pipe_pkg::word_t      if_inst,
    input  wire mips_pipe_pkg::word_t      if_pc_plus4,
    input  wire logic                      if_valid,
    input  wire logic                      branch_taken,
    input  wire mips_isa_pkg::reg_num_t    ex_dest,
    input  wire logic                      ex_reg_write,
    input  wire mips_isa_pkg::reg_num_t    mem_dest,
    input  wire logic                      mem_reg_write,
    input  wire logic                      wb_en,
    input  wire mips_isa_pkg::reg_num_t    wb_num,
    input  wire mips_pipe_pkg::word_t      wb_data,
    output logic                           hold,
    output logic                           jump_taken,
    output mips_pipe_pkg::word_t           jump_target,
    output logic                           id_valid,
    output mips_pipe_pkg::alu_op_t         id_alu_op,
    output logic                           id_alu_src_imm,
    output mips_pipe_pkg::word_t           id_rs_data,
    output mips_pipe_pkg::word_t           id_rt_data,
    output mips_pipe_pkg::word_t           id_imm,
    output mips_isa_pkg::reg_num_t         id_dest,
    output logic                           id_reg_write,
    output logic                           id_mem_read,
    output logic                           id_mem_write,
    output mips_pipe_pkg::branch_kind_t    id_branch_kind,
    output mips_pipe_pkg::word_t           id_pc_plus4,
    output logic                           id_halt
);
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    word_t        regs [0:`MIPS_REG_COUNT-1];
    opcode_t      opcode;
    funct_t       funct;
    reg_num_t     rs;
    reg_num_t     rt;
    reg_num_t     rd;
    imm_t         imm;
    jump_index_t  jump_index;
    word_t        imm_ext;
    word_t        rs_data;
    word_t        rt_data;
    alu_op_t      alu_op;
    branch_kind_t branch_kind;
    reg_num_t     dest;
    logic         alu_src_imm;
    logic         zero_ext;
    logic         reg_write;
    logic         mem_read;
    logic         mem_write;
    logic         uses_rs;
    logic         uses_rt;
    logic         is_halt;
    logic         is_jump;
    logic         stall;
    logic         bubble;
    logic         halt_latched;

    function automatic logic hazard(reg_num_t src, reg_num_t dst, logic wr);
        return wr && (dst != '0) && (dst == src);
    endfunction

    assign opcode     = opcode_t'(if_inst[31:26]);
    assign rs         = if_inst[25:21];
    assign rt         = if_inst[20:16];
    assign rd         = if_inst[15:11];
    assign funct      = funct_t'(if_inst[5:0]);
    assign imm        = if_inst[15:0];
    assign jump_index = if_inst[25:0];

    always_comb begin
        alu_op      = ALU_ADD;
        alu_src_imm = 1'b0;
        zero_ext    = 1'b0;
        dest        = rd;
        reg_write   = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        branch_kind = BR_NONE;
        uses_rs     = 1'b0;
        uses_rt     = 1'b0;
        is_halt     = 1'b0;
        is_jump     = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                uses_rs   = 1'b1;
                uses_rt   = 1'b1;
                reg_write = 1'b1;
                case (funct)
                    FUNCT_ADD: alu_op = ALU_ADD;
                    FUNCT_SUB: alu_op = ALU_SUB;
                    FUNCT_AND: alu_op = ALU_AND;
                    FUNCT_OR:  alu_op = ALU_OR;
                    FUNCT_SLT: alu_op = ALU_SLT;
                    FUNCT_SYSCALL: begin
                        is_halt   = 1'b1;
                        uses_rs   = 1'b0;
                        uses_rt   = 1'b0;
                        reg_write = 1'b0;
                    end
                    default: reg_write = 1'b0; // unknown function is a no-op.
                endcase
            end
            OP_ADDI, OP_ANDI, OP_ORI, OP_LW: begin
                alu_src_imm = 1'b1;
                dest        = rt;
                reg_write   = 1'b1;
                uses_rs     = 1'b1;
                mem_read    = (opcode == OP_LW);
                zero_ext    = (opcode == OP_ANDI) || (opcode == OP_ORI);
                if (opcode == OP_ANDI) begin
                    alu_op = ALU_AND;
                end else if (opcode == OP_ORI) begin
                    alu_op = ALU_OR;
                end
            end
            OP_SW: begin
                alu_src_imm = 1'b1;
                mem_write   = 1'b1;
                uses_rs     = 1'b1;
                uses_rt     = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                branch_kind = (opcode == OP_BEQ) ? BR_EQ : BR_NE;
                uses_rs     = 1'b1;
                uses_rt     = 1'b1;
            end
            OP_J:    is_jump = 1'b1;
            default: ;
        endcase
    end

    assign imm_ext = zero_ext ? {{(`MIPS_XLEN-16){1'b0}}, imm}
                              : {{(`MIPS_XLEN-16){imm[15]}}, imm};

    // writeback result is visible to a read in the same cycle.
    assign rs_data = (rs == '0) ? '0 : (wb_en && wb_num == rs) ? wb_data : regs[rs];
    assign rt_data = (rt == '0) ? '0 : (wb_en && wb_num == rt) ? wb_data : regs[rt];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `MIPS_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && wb_num != '0) begin
            regs[wb_num] <= wb_data;
        end
    end

    // producers in EX or MEM block the read until they reach writeback.
    assign stall = if_valid &&
                   ((uses_rs && (hazard(rs, ex_dest, ex_reg_write) ||
                                 hazard(rs, mem_dest, mem_reg_write))) ||
                    (uses_rt && (hazard(rt, ex_dest, ex_reg_write) ||
                                 hazard(rt, mem_dest, mem_reg_write))));

    assign bubble      = !if_valid || branch_taken || stall || halt_latched;
    assign hold        = stall || halt_latched || (!bubble && is_halt);
    assign jump_taken  = !bubble && is_jump;
    assign jump_target = {if_pc_plus4[`MIPS_XLEN-1:28], jump_index, 2'b00};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_valid       <= 1'b0;
            id_reg_write   <= 1'b0;
            id_mem_read    <= 1'b0;
            id_mem_write   <= 1'b0;
            id_branch_kind <= BR_NONE;
            id_halt        <= 1'b0;
            halt_latched   <= 1'b0;
        end else begin
            id_valid       <= !bubble;
            id_reg_write   <= !bubble && reg_write;
            id_mem_read    <= !bubble && mem_read;
            id_mem_write   <= !bubble && mem_write;
            id_branch_kind <= bubble ? BR_NONE : branch_kind;
            id_halt        <= !bubble && is_halt;
            if (!bubble && is_halt) begin
                halt_latched <= 1'b1; // fetch stays frozen from here on.
            end
        end
    end

    always_ff @(posedge clk) begin
        id_alu_op      <= alu_op;
        id_alu_src_imm <= alu_src_imm;
        id_rs_data     <= rs_data;
        id_rt_data     <= rt_data;
        id_imm         <= imm_ext;
        id_dest        <= dest;
        id_pc_plus4    <= if_pc_plus4;
    end

endmodule

`default_nettype wire

// File: design/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_defines.svh"

module execute_stage (
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    input  wire logic                         id_valid,
    input  wire mips_pipe_pkg::alu_op_t       id_alu_op,
    input  wire logic                         id_alu_src_imm,
    input  wire mips_pipe_pkg::word_t         id_rs_data,
    input  wire mips_pipe_pkg::word_t         id_rt_data,
    input  wire mips_pipe_pkg::word_t         id_imm,
    input  wire mips_isa_pkg::reg_num_t       id_dest,
    input  wire logic                         id_reg_write,
    input  wire logic                         id_mem_read,
    input  wire logic                         id_mem_write,
    input  wire mips_pipe_pkg::branch_kind_t  id_branch_kind,
    input  wire mips_pipe_pkg::word_t         id_pc_plus4,
    input  wire logic                         id_halt,
    output logic                              branch_taken,
    output mips_pipe_pkg::word_t              branch_target,
    output mips_isa_pkg::reg_num_t            ex_dest,
    output logic                              ex_reg_write,
    output logic                              ex_valid,
    output mips_pipe_pkg::word_t              ex_result,
    output mips_pipe_pkg::word_t              ex_store_data,
    output logic                              ex_mem_read,
    output logic                              ex_mem_write,
    output logic                              ex_halt
);
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    word_t operand_b;
    word_t alu_result;
    logic  equal;

    assign operand_b = id_alu_src_imm ? id_imm : id_rt_data;

    always_comb begin
        case (id_alu_op)
            ALU_ADD: alu_result = id_rs_data + operand_b;
            ALU_SUB: alu_result = id_rs_data - operand_b;
            ALU_AND: alu_result = id_rs_data & operand_b;
            ALU_OR:  alu_result = id_rs_data | operand_b;
            ALU_SLT: alu_result = ($signed(id_rs_data) < $signed(operand_b)) ? word_t'(1) : '0;
            default: alu_result = '0;
        endcase
    end

    assign equal         = (id_rs_data == id_rt_data);
    assign branch_taken  = id_valid && (((id_branch_kind == BR_EQ) && equal) ||
                                        ((id_branch_kind == BR_NE) && !equal));
    assign branch_target = id_pc_plus4 + {id_imm[`MIPS_XLEN-3:0], 2'b00};

    // hazard view of the instruction now in EX.
    assign ex_dest      = id_dest;
    assign ex_reg_write = id_reg_write;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_valid     <= 1'b0;
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
            ex_halt      <= 1'b0;
        end else begin
            ex_valid     <= id_valid;
            ex_mem_read  <= id_mem_read;
            ex_mem_write <= id_mem_write;
            ex_halt      <= id_halt;
        end
    end

    always_ff @(posedge clk) begin
        ex_result     <= alu_result;
        ex_store_data <= id_rt_data;
    end

endmodule

`default_nettype wire

// File: design/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_defines.svh"

module fetch_stage (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 hold,
    input  wire logic                 jump_taken,
    input  wire mips_pipe_pkg::word_t jump_target,
    input  wire logic                 branch_taken,
    input  wire mips_pipe_pkg::word_t branch_target,
    input  wire mips_pipe_pkg::word_t inst,
    output mips_pipe_pkg::word_t      inst_addr,
    output mips_pipe_pkg::word_t      if_inst,
    output mips_pipe_pkg::word_t      if_pc_plus4,
    output logic                      if_valid
);
    import mips_pipe_pkg::*;

    word_t pc;
    word_t pc_plus4;
    word_t pc_next;

    assign inst_addr = pc;
    assign pc_plus4  = pc + word_t'(4);

    always_comb begin
        if (branch_taken) begin // older redirect wins.
            pc_next = branch_target;
        end else if (jump_taken) begin
            pc_next = jump_target;
        end else if (hold) begin
            pc_next = pc;
        end else begin
            pc_next = pc_plus4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc       <= `MIPS_RESET_PC;
            if_valid <= 1'b0;
        end else begin
            pc <= pc_next;
            if (branch_taken || jump_taken) begin
                if_valid <= 1'b0; // squash the wrong-path word.
            end else if (!hold) begin
                if_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            if_inst     <= inst;
            if_pc_plus4 <= pc_plus4;
        end
    end

endmodule

`default_nettype wire

// File: design/memory_stage.sv
`timescale 1ns/1ps
`default_nettype none

module memory_stage (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire mips_isa_pkg::reg_num_t  ex_dest,
    input  wire logic                    ex_reg_write,
    input  wire logic                    ex_valid,
    input  wire mips_pipe_pkg::word_t    ex_result,
    input  wire mips_pipe_pkg::word_t    ex_store_data,
    input  wire logic                    ex_mem_read,
    input  wire logic                    ex_mem_write,
    input  wire logic                    ex_halt,
    input  wire mips_pipe_pkg::word_t    mem_data_out,
    output mips_pipe_pkg::word_t         mem_addr,
    output mips_pipe_pkg::word_t         mem_data_in,
    output logic                         mem_write_en,
    output mips_isa_pkg::reg_num_t       mem_dest,
    output logic                         mem_reg_write,
    output logic                         wb_en,
    output mips_isa_pkg::reg_num_t       wb_num,
    output mips_pipe_pkg::word_t         wb_data,
    output logic                         halted
);
    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    word_t wb_select;

    assign mem_addr     = ex_result;
    assign mem_data_in  = ex_store_data;
    assign mem_write_en = ex_valid && ex_mem_write;
    assign wb_select    = ex_mem_read ? mem_data_out : ex_result;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_reg_write <= 1'b0;
            wb_en         <= 1'b0;
            halted        <= 1'b0;
        end else begin
            mem_reg_write <= ex_reg_write; // dest of the instruction entering MEM.
            wb_en         <= mem_reg_write;
            if (ex_valid && ex_halt) begin
                halted <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        mem_dest <= ex_dest;
        wb_num   <= mem_dest;
        wb_data  <= wb_select;
    end

endmodule

`default_nettype wire

// File: design/mips_core.sv
`timescale 1ns/1ps
`default_nettype none

module mips_core (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire mips_pipe_pkg::word_t inst,
    input  wire mips_pipe_pkg::word_t mem_data_out,
    output mips_pipe_pkg::word_t      inst_addr,
    output mips_pipe_pkg::word_t      mem_addr,
    output mips_pipe_pkg::word_t      mem_data_in,
    output logic                      mem_write_en,
    output logic                      halted
);
    import mips_pipe_pkg::*;

    word_t        if_inst;
    word_t        if_pc_plus4;
    logic         if_valid;
    logic         hold;
    logic         jump_taken;
    word_t        jump_target;
    logic         branch_taken;
    word_t        branch_target;
    logic         id_valid;
    alu_op_t      id_alu_op;
    logic         id_alu_src_imm;
    word_t        id_rs_data;
    word_t        id_rt_data;
    word_t        id_imm;
    logic [4:0]   id_dest;
    logic         id_reg_write;
    logic         id_mem_read;
    logic         id_mem_write;
    branch_kind_t id_branch_kind;
    word_t        id_pc_plus4;
    logic         id_halt;
    logic [4:0]   ex_dest;
    logic         ex_reg_write;
    logic         ex_valid;
    word_t        ex_result;
    word_t        ex_store_data;
    logic         ex_mem_read;
    logic         ex_mem_write;
    logic         ex_halt;
    logic [4:0]   mem_dest;
    logic         mem_reg_write;
    logic         wb_en;
    logic [4:0]   wb_num;
    word_t        wb_data;

    fetch_stage u_fetch (
        .clk, .rst_n, .hold,
        .jump_taken, .jump_target,
        .branch_taken, .branch_target,
        .inst, .inst_addr,
        .if_inst, .if_pc_plus4, .if_valid
    );

    decode_stage u_decode (
        .clk, .rst_n,
        .if_inst, .if_pc_plus4, .if_valid,
        .branch_taken,
        .ex_dest, .ex_reg_write,
        .mem_dest, .mem_reg_write,
        .wb_en, .wb_num, .wb_data,
        .hold, .jump_taken, .jump_target,
        .id_valid, .id_alu_op, .id_alu_src_imm,
        .id_rs_data, .id_rt_data, .id_imm,
        .id_dest, .id_reg_write, .id_mem_read, .id_mem_write,
        .id_branch_kind, .id_pc_plus4, .id_halt
    );

    execute_stage u_execute (
        .clk, .rst_n,
        .id_valid, .id_alu_op, .id_alu_src_imm,
        .id_rs_data, .id_rt_data, .id_imm,
        .id_dest, .id_reg_write, .id_mem_read, .id_mem_write,
        .id_branch_kind, .id_pc_plus4, .id_halt,
        .branch_taken, .branch_target,
        .ex_dest, .ex_reg_write, .ex_valid,
        .ex_result, .ex_store_data,
        .ex_mem_read, .ex_mem_write, .ex_halt
    );

    memory_stage u_memory (
        .clk, .rst_n,
        .ex_dest, .ex_reg_write, .ex_valid,
        .ex_result, .ex_store_data,
        .ex_mem_read, .ex_mem_write, .ex_halt,
        .mem_data_out, .mem_addr, .mem_data_in, .mem_write_en,
        .mem_dest, .mem_reg_write,
        .wb_en, .wb_num, .wb_data,
        .halted
    );

endmodule

`default_nettype wire

// File: design/mips_defines.svh
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

`define MIPS_XLEN       32
`define MIPS_REG_COUNT  32
`define MIPS_RESET_PC   32'h0000_0000
`define MIPS_HALT_FUNCT 6'h0c // syscall.

`endif

// File: design/mips_isa_pkg.sv
`default_nettype none

`include "mips_defines.svh"

package mips_isa_pkg;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_t;

    typedef enum logic [5:0] {
        FUNCT_SYSCALL = `MIPS_HALT_FUNCT,
        FUNCT_ADD     = 6'h20,
        FUNCT_SUB     = 6'h22,
        FUNCT_AND     = 6'h24,
        FUNCT_OR      = 6'h25,
        FUNCT_SLT     = 6'h2a
    } funct_t;

    typedef logic [4:0]  reg_num_t;
    typedef logic [15:0] imm_t;
    typedef logic [25:0] jump_index_t;

endpackage

`default_nettype wire

// File: design/mips_pipe_pkg.sv
`default_nettype none

`include "mips_defines.svh"

package mips_pipe_pkg;

    typedef logic [`MIPS_XLEN-1:0] word_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_t;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_EQ,
        BR_NE
    } branch_kind_t;

endpackage

`default_nettype wire

// File: src.f
+incdir+design
design/mips_isa_pkg.sv
design/mips_pipe_pkg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/memory_stage.sv
design/mips_core.sv
testbench/mips_core_tb.sv

// File: testbench/mips_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mips_core_tb;

    localparam int CLK_PERIOD_NS = 4;
    localparam int NUM_PROGS     = 8;
    localparam int PROG_LEN      = 40;
    localparam int DATA_WORDS    = 64;
    localparam int RESET_CYCLES  = 5;
    localparam int HOLD_CYCLES   = 10;
    localparam int WATCHDOG_NS   = NUM_PROGS * CLK_PERIOD_NS *
                                   (PROG_LEN * 6 + RESET_CYCLES + HOLD_CYCLES + 1) + 2000;

    localparam logic [5:0]  OP_R      = 6'h00;
    localparam logic [5:0]  OP_J      = 6'h02;
    localparam logic [5:0]  OP_BEQ    = 6'h04;
    localparam logic [5:0]  OP_BNE    = 6'h05;
    localparam logic [5:0]  OP_ADDI   = 6'h08;
    localparam logic [5:0]  OP_ANDI   = 6'h0c;
    localparam logic [5:0]  OP_ORI    = 6'h0d;
    localparam logic [5:0]  OP_LW     = 6'h23;
    localparam logic [5:0]  OP_SW     = 6'h2b;
    localparam logic [5:0]  F_ADD     = 6'h20;
    localparam logic [5:0]  F_SUB     = 6'h22;
    localparam logic [5:0]  F_AND     = 6'h24;
    localparam logic [5:0]  F_OR      = 6'h25;
    localparam logic [5:0]  F_SLT     = 6'h2a;
    localparam logic [31:0] HALT_WORD = 32'h0000_000c; // syscall.
    localparam logic [31:0] FROZEN_ADDR = 32'(PROG_LEN * 4); // word after the halt.

    logic        clk;
    logic        rst_n;
    logic [31:0] inst;
    logic [31:0] mem_data_out;
    logic [31:0] inst_addr;
    logic [31:0] mem_addr;
    logic [31:0] mem_data_in;
    logic        mem_write_en;
    logic        halted;

    logic [31:0] prog [0:63];
    logic [31:0] dmem [0:DATA_WORDS-1];
    logic [31:0] model_mem [0:DATA_WORDS-1];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    integer      seed;
    int          errors;
    int          stores;

    mips_core dut (
        .clk(clk),
        .rst_n(rst_n),
        .inst(inst),
        .mem_data_out(mem_data_out),
        .inst_addr(inst_addr),
        .mem_addr(mem_addr),
        .mem_data_in(mem_data_in),
        .mem_write_en(mem_write_en),
        .halted(halted)
    );

    // both memories answer in the same cycle.
    assign inst         = (inst_addr < 32'(PROG_LEN * 4)) ? prog[inst_addr[7:2]] : HALT_WORD;
    assign mem_data_out = dmem[mem_addr[7:2]];

    always #(CLK_PERIOD_NS / 2) clk = ~clk;

    function automatic logic [31:0] rand_word();
        rand_word = $random(seed);
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors++;
        $display("FAILED %s: expected %h, actual %h", name, expected, actual);
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("ERROR: %s", msg);
    endtask

    task automatic gen_program();
        logic [31:0] r;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] offset;
        int          kind;
        int          target;
        for (int i = 0; i < PROG_LEN - 1; i++) begin
            r      = rand_word();
            rs     = {2'b00, r[2:0]}; // few registers, so many dependences.
            rt     = {2'b00, r[5:3]};
            rd     = {2'b00, r[8:6]};
            offset = {10'd0, r[14:11], 2'b00};
            kind   = int'(r[31:28]);
            target = i + 1 + int'(r[10:9]); // forward only.
            if (target > PROG_LEN - 1) begin
                target = PROG_LEN - 1;
            end
            case (kind)
                0:       prog[i] = {OP_R, rs, rt, rd, 5'd0, F_ADD};
                1:       prog[i] = {OP_R, rs, rt, rd, 5'd0, F_SUB};
                2:       prog[i] = {OP_R, rs, rt, rd, 5'd0, F_AND};
                3:       prog[i] = {OP_R, rs, rt, rd, 5'd0, F_OR};
                4:       prog[i] = {OP_R, rs, rt, rd, 5'd0, F_SLT};
                5:       prog[i] = {OP_ADDI, rs, rt, r[27:12]};
                6:       prog[i] = {OP_ANDI, rs, rt, r[27:12]};
                7:       prog[i] = {OP_ORI, rs, rt, r[27:12]};
                8, 9:    prog[i] = {OP_LW, 5'd0, rt, offset};
                10, 11:  prog[i] = {OP_SW, 5'd0, rt, offset};
                12:      prog[i] = {OP_ADDI, 5'd0, rt, r[27:12]};
                13:      prog[i] = {OP_BEQ, rs, rt, 16'(target - i - 1)};
                14:      prog[i] = {OP_BNE, rs, rt, 16'(target - i - 1)};
                default: prog[i] = {OP_J, 26'(target)};
            endcase
        end
        prog[PROG_LEN-1] = HALT_WORD;
    endtask

    task automatic load_data();
        for (int i = 0; i < DATA_WORDS; i++) begin
            dmem[i]      = rand_word();
            model_mem[i] = dmem[i];
        end
    endtask

    // sequential ISA model; collects the stores in program order.
    task automatic build_expected();
        logic [31:0] regs [0:31];
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sext;
        logic [31:0] addr;
        logic [31:0] res;
        logic [4:0]  dst;
        logic        wr;
        int          pc;
        for (int k = 0; k < 32; k++) begin
            regs[k] = '0;
        end
        exp_addr.delete();
        exp_data.delete();
        pc = 0;
        while (pc < PROG_LEN && prog[pc] != HALT_WORD) begin
            ins  = prog[pc];
            a    = regs[ins[25:21]];
            b    = regs[ins[20:16]];
            sext = {{16{ins[15]}}, ins[15:0]};
            addr = a + sext;
            dst  = ins[20:16];
            wr   = 1'b1;
            res  = '0;
            pc   = pc + 1;
            case (ins[31:26])
                OP_R: begin
                    dst = ins[15:11];
                    case (ins[5:0])
                        F_ADD:   res = a + b;
                        F_SUB:   res = a - b;
                        F_AND:   res = a & b;
                        F_OR:    res = a | b;
                        F_SLT:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: wr = 1'b0;
                    endcase
                end
                OP_ADDI: res = addr;
                OP_ANDI: res = a & {16'd0, ins[15:0]};
                OP_ORI:  res = a | {16'd0, ins[15:0]};
                OP_LW:   res = model_mem[addr[7:2]];
                OP_SW: begin
                    wr = 1'b0;
                    exp_addr.push_back(addr);
                    exp_data.push_back(b);
                    model_mem[addr[7:2]] = b;
                end
                OP_BEQ: begin
                    wr = 1'b0;
                    if (a == b) begin
                        pc = pc + $signed(sext);
                    end
                end
                OP_BNE: begin
                    wr = 1'b0;
                    if (a != b) begin
                        pc = pc + $signed(sext);
                    end
                end
                OP_J: begin
                    wr = 1'b0;
                    pc = int'(ins[25:0]);
                end
                default: wr = 1'b0;
            endcase
            if (wr && dst != 5'd0) begin
                regs[dst] = res;
            end
        end
    endtask

    task automatic reset_and_load(input int p);
        rst_n = 1'b0;
        gen_program();
        load_data();
        build_expected();
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            if (mem_write_en !== 1'b0 || halted !== 1'b0) begin
                report_error($sformatf("prog %0d: write enable or halted high in reset", p));
            end
        end
        rst_n = 1'b1;
        @(negedge clk);
        if (mem_write_en !== 1'b0 || halted !== 1'b0) begin
            report_error($sformatf("prog %0d: write enable or halted high after reset", p));
        end
    endtask

    task automatic check_program(input int p);
        logic [31:0] want_addr;
        logic [31:0] want_data;
        logic        done;
        int          n;
        n    = 0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk); // data port is settled mid-cycle.
            if (mem_write_en === 1'b1) begin
                if (halted === 1'b1) begin
                    report_error($sformatf("prog %0d: store issued after halt", p));
                end else if (exp_addr.size() == 0) begin
                    report_error($sformatf("prog %0d: store to %h not in the model", p, mem_addr));
                end else begin
                    want_addr = exp_addr.pop_front();
                    want_data = exp_data.pop_front();
                    if (mem_addr !== want_addr) begin
                        report_mismatch($sformatf("prog %0d store %0d addr", p, n),
                                        want_addr, mem_addr);
                    end
                    if (mem_data_in !== want_data) begin
                        report_mismatch($sformatf("prog %0d store %0d data", p, n),
                                        want_data, mem_data_in);
                    end
                    n++;
                    stores++;
                end
                dmem[mem_addr[7:2]] = mem_data_in;
            end
            done = (halted === 1'b1);
        end
        repeat (HOLD_CYCLES) begin
            @(negedge clk);
            if (halted !== 1'b1) begin
                report_error($sformatf("prog %0d: halted dropped after rising", p));
            end
            if (mem_write_en !== 1'b0) begin
                report_error($sformatf("prog %0d: store issued after halt", p));
            end
            if (inst_addr !== FROZEN_ADDR) begin
                report_mismatch($sformatf("prog %0d fetch addr after halt", p),
                                FROZEN_ADDR, inst_addr);
            end
        end
        if (exp_addr.size() != 0) begin
            report_error($sformatf("prog %0d: %0d stores never issued", p, exp_addr.size()));
        end
        for (int i = 0; i < DATA_WORDS; i++) begin
            if (dmem[i] !== model_mem[i]) begin
                report_mismatch($sformatf("prog %0d dmem[%0d]", p, i), model_mem[i], dmem[i]);
            end
        end
    endtask

    initial begin
        clk    = 1'b0;
        rst_n  = 1'b0;
        seed   = 32'h2867;
        errors = 0;
        stores = 0;
        for (int p = 0; p < NUM_PROGS; p++) begin
            reset_and_load(p);
            check_program(p);
        end
        $display("programs: %0d, stores checked: %0d, errors: %0d", NUM_PROGS, stores, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: halted did not rise within %0d ns, errors: %0d", WATCHDOG_NS, errors);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire
